// File: src/corr_settings.svh
`ifndef CORR_SETTINGS_SVH
`define CORR_SETTINGS_SVH

// --------------------
// Array geometry
// --------------------

// Antennas sampled per clock, one bit each for re and im
`define ANT_COUNT 24

// Slots per pass, one antenna pair per slot
`define MRATE 12

// Enough bits to index MRATE slots
`define SLOT_BITS 4

// --------------------
// Datapath widths
// --------------------

// One cos or sin count, wraps at 2**ACCUM_BITS
`define ACCUM_BITS 8

// Samples per integration block
`define BLEN_BITS 16

`endif

// File: src/corr_pkg.sv
`default_nettype none

`include "corr_settings.svh"

package corr_pkg;

   // --------------------
   // Counts and slots
   // --------------------

   // One unsigned correlation count
   typedef logic [`ACCUM_BITS-1:0] accum_t;

   // Accumulator word, sin in the upper half
   typedef struct packed {
      accum_t sin_cnt;
      accum_t cos_cnt;
   } vis_t;

   // Slot within a pass
   typedef logic [`SLOT_BITS-1:0] slot_t;

   // --------------------
   // Antenna pairs
   // --------------------

   typedef logic [4:0] ant_t;

   // Pair (a, b), a in the upper five bits
   typedef struct packed {
      ant_t a;
      ant_t b;
   } pair_t;

   // Fixed pair per slot, indexed by slot number
   localparam pair_t PAIR_TABLE [`MRATE] = '{
      '{a: 5'd0,  b: 5'd3},  '{a: 5'd1,  b: 5'd3},  '{a: 5'd2,  b: 5'd3},
      '{a: 5'd3,  b: 5'd4},  '{a: 5'd4,  b: 5'd5},  '{a: 5'd0,  b: 5'd5},
      '{a: 5'd1,  b: 5'd2},  '{a: 5'd6,  b: 5'd7},  '{a: 5'd8,  b: 5'd9},
      '{a: 5'd10, b: 5'd11}, '{a: 5'd12, b: 5'd23}, '{a: 5'd22, b: 5'd23}
   };

endpackage

`default_nettype wire

// File: src/accum_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_settings.svh"

module accum_ram (
   input  wire logic             clk_x,
   input  wire logic             we,
   input  wire corr_pkg::slot_t  waddr,
   input  wire corr_pkg::slot_t  raddr,
   input  wire corr_pkg::vis_t   wdata,
   output corr_pkg::vis_t        rdata
);

   import corr_pkg::*;

   // One cos/sin word per slot
   vis_t mem [`MRATE];

   // Counts start from zero after configuration
   initial begin
      for (int i = 0; i < `MRATE; i++) begin
         mem[i] = '0;
      end
   end

   // --------------------
   // Write port
   // --------------------

   always_ff @(posedge clk_x) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // --------------------
   // Read port
   // --------------------

   // Registered read, data one cycle after raddr
   always_ff @(posedge clk_x) begin
      rdata <= mem[raddr];
   end

endmodule

`default_nettype wire

// File: src/correlate_cos_sin.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_settings.svh"

module correlate_cos_sin (
   input  wire logic              clk_x,
   input  wire logic              rst,
   input  wire logic              en,
   input  wire logic              ar,
   input  wire logic              br,
   input  wire logic              bi,
   input  wire corr_pkg::accum_t  dcos,
   input  wire corr_pkg::accum_t  dsin,
   output logic                   valid,
   output corr_pkg::accum_t       qcos,
   output corr_pkg::accum_t       qsin,
   output logic                   oc,
   output logic                   os
);

   // One-bit products, equal signs give +1
   logic match_cos;
   logic match_sin;

   // Carry bit on top catches the wrap
   logic [`ACCUM_BITS:0] sum_cos;
   logic [`ACCUM_BITS:0] sum_sin;

   assign match_cos = (ar == br);
   assign match_sin = (ar == bi);

   assign sum_cos = {1'b0, dcos} + {{`ACCUM_BITS{1'b0}}, match_cos};
   assign sum_sin = {1'b0, dsin} + {{`ACCUM_BITS{1'b0}}, match_sin};

   // --------------------
   // Control
   // --------------------

   // Valid and wrap pulses track en one cycle later
   always_ff @(posedge clk_x) begin
      if (rst) begin
         valid <= 1'b0;
         oc    <= 1'b0;
         os    <= 1'b0;
      end else begin
         valid <= en;
         oc    <= en & sum_cos[`ACCUM_BITS];
         os    <= en & sum_sin[`ACCUM_BITS];
      end
   end

   // --------------------
   // Sums
   // --------------------

   always_ff @(posedge clk_x) begin
      if (en) begin
         qcos <= sum_cos[`ACCUM_BITS-1:0];
         qsin <= sum_sin[`ACCUM_BITS-1:0];
      end
   end

endmodule

`default_nettype wire

// File: src/slot_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_settings.svh"

module slot_counter (
   input  wire logic                  clk_x,
   input  wire logic                  rst,
   input  wire logic                  run,
   input  wire logic [`BLEN_BITS-1:0] block_len,
   output corr_pkg::slot_t            slot,
   output logic                       pass_last,
   output logic                       block_first,
   output logic                       block_last
);

   // Sample index within the integration block
   logic [`BLEN_BITS-1:0] sample_idx;

   assign pass_last   = (slot == `SLOT_BITS'(`MRATE - 1));
   assign block_first = (sample_idx == '0);
   assign block_last  = (sample_idx == block_len - `BLEN_BITS'd1);

   // --------------------
   // Slot count
   // --------------------

   // Parked at 0 between passes so each pass starts on slot 0
   always_ff @(posedge clk_x) begin
      if (rst || !run) begin
         slot <= '0;
      end else if (pass_last) begin
         slot <= '0;
      end else begin
         slot <= slot + 1'b1;
      end
   end

   // --------------------
   // Sample count
   // --------------------

   // Steps once per finished pass, wraps after block_len samples
   always_ff @(posedge clk_x) begin
      if (rst) begin
         sample_idx <= '0;
      end else if (run && pass_last) begin
         if (block_last) begin
            sample_idx <= '0;
         end else begin
            sample_idx <= sample_idx + 1'b1;
         end
      end
   end

   // Slot stays inside the pair table
   slot_in_range: assert property (@(posedge clk_x) disable iff (rst)
      slot <= `SLOT_BITS'(`MRATE - 1))
      else $error("slot_counter: slot %0d out of range", slot);

endmodule

`default_nettype wire

// File: src/corr_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_settings.svh"

module corr_sequencer (
   input  wire logic             clk_x,
   input  wire logic             rst,
   input  wire logic             sample_vld,
   input  wire corr_pkg::slot_t  slot,
   input  wire logic             pass_last,
   input  wire logic             block_first,
   input  wire logic             block_last,
   output logic                  run,
   output logic                  load,
   output logic                  en,
   output logic                  sw,
   output logic                  dump,
   output logic                  busy,
   output logic                  missed,
   output corr_pkg::slot_t       rd
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_LOAD,
      ST_PASS,
      ST_DRAIN
   } state_t;

   state_t state;
   // Second of the two write-back cycles
   logic   drain_cnt;

   // --------------------
   // Decoded outputs
   // --------------------

   assign load = (state == ST_LOAD);
   assign run  = (state == ST_PASS);
   assign en   = (state == ST_PASS);
   assign busy = (state != ST_IDLE);
   // Slot counter already walks the pass
   assign rd   = slot;

   // --------------------
   // FSM
   // --------------------

   always_ff @(posedge clk_x) begin
      if (rst) begin
         state     <= ST_IDLE;
         drain_cnt <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (sample_vld) begin
                  state <= ST_LOAD;
               end
            end
            ST_LOAD: begin
               state <= ST_PASS;
            end
            ST_PASS: begin
               if (pass_last) begin
                  state     <= ST_DRAIN;
                  drain_cnt <= 1'b0;
               end
            end
            ST_DRAIN: begin
               // Hold busy until the last slot is written back
               drain_cnt <= 1'b1;
               if (drain_cnt) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Clear and dump marks, fixed for the whole pass
   always_ff @(posedge clk_x) begin
      if (rst) begin
         sw   <= 1'b0;
         dump <= 1'b0;
      end else if (state == ST_LOAD) begin
         sw   <= block_first;
         dump <= block_last;
      end
   end

   // Sticky, a sample during a pass is dropped
   always_ff @(posedge clk_x) begin
      if (rst) begin
         missed <= 1'b0;
      end else if (sample_vld && state != ST_IDLE) begin
         missed <= 1'b1;
      end
   end

   // One unbroken run of MRATE slots per pass
   en_run_len: assert property (@(posedge clk_x) disable iff (rst)
      $rose(en) |-> en [*`MRATE] ##1 !en)
      else $error("corr_sequencer: en length differs from slot count");

endmodule

`default_nettype wire

// File: src/correlator_sdp.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_settings.svh"

module correlator_sdp (
   input  wire logic                  clk_x,
   input  wire logic                  rst,
   input  wire logic                  load,
   input  wire logic                  en,
   input  wire logic                  sw,
   input  wire logic                  dump,
   input  wire logic [`ANT_COUNT-1:0] re,
   input  wire logic [`ANT_COUNT-1:0] im,
   input  wire corr_pkg::slot_t       rd,
   output logic                       vis_vld,
   output corr_pkg::vis_t             vis,
   output corr_pkg::slot_t            vis_slot,
   output logic                       overflow_cos,
   output logic                       overflow_sin
);

   import corr_pkg::*;

   // Sample held for the whole pass
   logic [`ANT_COUNT-1:0] re_q;
   logic [`ANT_COUNT-1:0] im_q;

   pair_t  pair;
   vis_t   ram_q;
   vis_t   wdata;
   accum_t dcos;
   accum_t dsin;
   accum_t qcos;
   accum_t qsin;

   // Stage 1, beside the RAM read
   logic   go;
   logic   ar;
   logic   br;
   logic   bi;
   logic   sw_d1;
   logic   dump_d1;
   slot_t  slot_d1;

   // Stage 2, beside the sum
   logic   dump_d2;
   slot_t  slot_d2;
   logic   valid;
   logic   oc;
   logic   os;

   always_ff @(posedge clk_x) begin
      if (load) begin
         re_q <= re;
         im_q <= im;
      end
   end

   // --------------------
   // Pair select
   // --------------------

   assign pair = PAIR_TABLE[rd];

   always_ff @(posedge clk_x) begin
      if (rst) begin
         go <= 1'b0;
      end else begin
         go <= en;
      end
   end

   always_ff @(posedge clk_x) begin
      ar      <= re_q[pair.a];
      br      <= re_q[pair.b];
      bi      <= im_q[pair.b];
      sw_d1   <= sw;
      dump_d1 <= dump;
      slot_d1 <= rd;
      dump_d2 <= dump_d1;
      slot_d2 <= slot_d1;
   end

   // First pass of a block starts from zero
   assign dcos = sw_d1 ? '0 : ram_q.cos_cnt;
   assign dsin = sw_d1 ? '0 : ram_q.sin_cnt;

   // --------------------
   // Accumulate
   // --------------------

   correlate_cos_sin u_corr (
      .clk_x (clk_x),
      .rst   (rst),
      .en    (go),
      .ar    (ar),
      .br    (br),
      .bi    (bi),
      .dcos  (dcos),
      .dsin  (dsin),
      .valid (valid),
      .qcos  (qcos),
      .qsin  (qsin),
      .oc    (oc),
      .os    (os)
   );

   assign wdata = '{sin_cnt: qsin, cos_cnt: qcos};

   // Write-back lands two slots behind the read
   accum_ram u_ram (
      .clk_x (clk_x),
      .we    (valid),
      .waddr (slot_d2),
      .raddr (rd),
      .wdata (wdata),
      .rdata (ram_q)
   );

   // --------------------
   // Visibility out
   // --------------------

   always_ff @(posedge clk_x) begin
      if (rst) begin
         vis_vld      <= 1'b0;
         overflow_cos <= 1'b0;
         overflow_sin <= 1'b0;
      end else begin
         vis_vld <= valid & dump_d2;
         if (oc) begin
            overflow_cos <= 1'b1;
         end
         if (os) begin
            overflow_sin <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_x) begin
      vis      <= wdata;
      vis_slot <= slot_d2;
   end

   // Strobe three cycles after its slot's en, slot number carried intact
   vis_after_en: assert property (@(posedge clk_x) disable iff (rst)
      vis_vld |-> $past(en, 3) && (vis_slot == $past(rd, 3)))
      else $error("correlator_sdp: vis_vld out of step with the pass");

endmodule

`default_nettype wire

// File: src/correlator_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_settings.svh"

module correlator_top (
   input  wire logic                  clk_x,
   input  wire logic                  rst,
   input  wire logic                  sample_vld,
   input  wire logic [`ANT_COUNT-1:0] re,
   input  wire logic [`ANT_COUNT-1:0] im,
   input  wire logic [`BLEN_BITS-1:0] block_len,
   output logic                       vis_vld,
   output corr_pkg::vis_t             vis,
   output corr_pkg::slot_t            vis_slot,
   output logic                       overflow_cos,
   output logic                       overflow_sin,
   output logic                       busy,
   output logic                       missed
);

   import corr_pkg::*;

   // Sequencer and counter handshake
   logic  run;
   slot_t slot;
   logic  pass_last;
   logic  block_first;
   logic  block_last;

   // Sequencer to correlator block
   logic  load;
   logic  en;
   logic  sw;
   logic  dump;
   slot_t rd;

   // --------------------
   // Control
   // --------------------

   corr_sequencer u_seq (
      .clk_x       (clk_x),
      .rst         (rst),
      .sample_vld  (sample_vld),
      .slot        (slot),
      .pass_last   (pass_last),
      .block_first (block_first),
      .block_last  (block_last),
      .run         (run),
      .load        (load),
      .en          (en),
      .sw          (sw),
      .dump        (dump),
      .busy        (busy),
      .missed      (missed),
      .rd          (rd)
   );

   slot_counter u_cnt (
      .clk_x       (clk_x),
      .rst         (rst),
      .run         (run),
      .block_len   (block_len),
      .slot        (slot),
      .pass_last   (pass_last),
      .block_first (block_first),
      .block_last  (block_last)
   );

   // --------------------
   // Datapath
   // --------------------

   correlator_sdp u_sdp (
      .clk_x        (clk_x),
      .rst          (rst),
      .load         (load),
      .en           (en),
      .sw           (sw),
      .dump         (dump),
      .re           (re),
      .im           (im),
      .rd           (rd),
      .vis_vld      (vis_vld),
      .vis          (vis),
      .vis_slot     (vis_slot),
      .overflow_cos (overflow_cos),
      .overflow_sin (overflow_sin)
   );

endmodule

`default_nettype wire

// File: testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// --------------------
// Reference counts
// --------------------

// Unwrapped counts per slot, folded to the count width on readout
int model_cos [`MRATE];
int model_sin [`MRATE];

// Antenna bit as its signed value, 1 is +1 and 0 is -1
function automatic int antenna_sign(input logic b);
   return b ? 1 : -1;
endfunction

// New block, nothing carried over from the last one
task automatic clear_model();
   for (int k = 0; k < `MRATE; k++) begin
      model_cos[k] = 0;
      model_sin[k] = 0;
   end
endtask

// One sample, one signed product per pair and component
task automatic accumulate_sample(input logic [`ANT_COUNT-1:0] s_re,
                                 input logic [`ANT_COUNT-1:0] s_im);
   corr_pkg::pair_t p;
   for (int k = 0; k < `MRATE; k++) begin
      p = corr_pkg::PAIR_TABLE[k];
      // cos term re[a] * re[b]
      if (antenna_sign(s_re[p.a]) * antenna_sign(s_re[p.b]) > 0) begin
         model_cos[k] = model_cos[k] + 1;
      end
      // sin term re[a] * im[b]
      if (antenna_sign(s_re[p.a]) * antenna_sign(s_im[p.b]) > 0) begin
         model_sin[k] = model_sin[k] + 1;
      end
   end
endtask

// Count as an 8-bit register shows it, wrapped at 256
function automatic corr_pkg::vis_t expected_vis(input int k);
   corr_pkg::vis_t v;
   v.cos_cnt = corr_pkg::accum_t'(model_cos[k] % (1 << `ACCUM_BITS));
   v.sin_cnt = corr_pkg::accum_t'(model_sin[k] % (1 << `ACCUM_BITS));
   return v;
endfunction

`endif

// File: testbench/tb_correlator.sv
`timescale 1ns/1ps
`default_nettype none

`include "corr_settings.svh"

module tb_correlator;

   import corr_pkg::*;

   // --------------------
   // Run constants
   // --------------------

   localparam int CLK_PERIOD = 40;
   localparam int RST_CYCLES = 10;
   // Strobe to strobe, one pass plus write-back fits inside
   localparam int SPACING    = 16;
   // Reset, drain and the dropped sample
   localparam int WD_MARGIN  = 400;
   localparam logic [31:0] SEED = 32'h1a921908;

   localparam logic [1:0] MODE_RANDOM = 2'd0;
   localparam logic [1:0] MODE_ONES   = 2'd1;
   localparam logic [1:0] MODE_ALT    = 2'd2;

   // Block length, blocks per row, data mode, miss test, overflow expected
   typedef struct packed {
      logic [`BLEN_BITS-1:0] blen;
      logic [7:0]            n_blocks;
      logic [1:0]            mode;
      logic                  miss;
      logic                  exp_ovf;
   } row_t;

   localparam int N_ROWS = 5;

   // Overflow row last, the flags never clear
   localparam row_t ROWS [N_ROWS] = '{
      '{blen: 16'd4,   n_blocks: 8'd2, mode: MODE_RANDOM, miss: 1'b0, exp_ovf: 1'b0},
      '{blen: 16'd2,   n_blocks: 8'd2, mode: MODE_ALT,    miss: 1'b0, exp_ovf: 1'b0},
      '{blen: 16'd1,   n_blocks: 8'd3, mode: MODE_RANDOM, miss: 1'b0, exp_ovf: 1'b0},
      '{blen: 16'd3,   n_blocks: 8'd1, mode: MODE_RANDOM, miss: 1'b1, exp_ovf: 1'b0},
      '{blen: 16'd300, n_blocks: 8'd1, mode: MODE_ONES,   miss: 1'b0, exp_ovf: 1'b1}
   };

   // --------------------
   // DUT
   // --------------------

   logic                  clk_x;
   logic                  rst;
   logic                  sample_vld;
   logic [`ANT_COUNT-1:0] re;
   logic [`ANT_COUNT-1:0] im;
   logic [`BLEN_BITS-1:0] block_len;
   logic                  vis_vld;
   vis_t                  vis;
   slot_t                 vis_slot;
   logic                  overflow_cos;
   logic                  overflow_sin;
   logic                  busy;
   logic                  missed;

   // Dump-pass words still to come, in slot order
   vis_t  exp_vis_q [$];
   slot_t exp_slot_q [$];
   int    errors;
   int    vis_seen;
   int    cur_blen;
   bit    exp_missed;

   `include "tb_model.svh"

   correlator_top dut0 (
      .clk_x        (clk_x),
      .rst          (rst),
      .sample_vld   (sample_vld),
      .re           (re),
      .im           (im),
      .block_len    (block_len),
      .vis_vld      (vis_vld),
      .vis          (vis),
      .vis_slot     (vis_slot),
      .overflow_cos (overflow_cos),
      .overflow_sin (overflow_sin),
      .busy         (busy),
      .missed       (missed)
   );

   initial begin
      clk_x = 1'b0;
      forever #(CLK_PERIOD / 2) clk_x = ~clk_x;
   end

   // --------------------
   // Monitor
   // --------------------

   // Sampled mid-cycle, well away from the driving edge
   always @(negedge clk_x) begin : vis_monitor
      vis_t  exp_v;
      slot_t exp_s;
      if (!rst && vis_vld) begin
         vis_seen = vis_seen + 1;
         assert (exp_vis_q.size() != 0) else begin
            errors = errors + 1;
            $display("Visibility strobe at %0t for slot %0d with no dump pass pending",
                     $time, vis_slot);
         end
         if (exp_vis_q.size() != 0) begin
            exp_v = exp_vis_q.pop_front();
            exp_s = exp_slot_q.pop_front();
            assert (vis_slot == exp_s) else begin
               errors = errors + 1;
               $display("ERROR %0t: vis_slot %0d, expected %0d", $time, vis_slot, exp_s);
            end
            assert (vis == exp_v) else begin
               errors = errors + 1;
               $display("ERROR %0t: slot %0d cos %0d sin %0d, expected cos %0d sin %0d",
                        $time, vis_slot, vis.cos_cnt, vis.sin_cnt,
                        exp_v.cos_cnt, exp_v.sin_cnt);
            end
            // Single-sample blocks hold one product at most
            if (cur_blen == 1) begin
               assert (vis.cos_cnt <= 1 && vis.sin_cnt <= 1) else begin
                  errors = errors + 1;
                  $display("ERROR %0t: slot %0d count above 1 with block_len 1",
                           $time, vis_slot);
               end
            end
         end
      end
   end

   // --------------------
   // Stimulus
   // --------------------

   task automatic make_sample(input logic [1:0] mode, input int idx,
                              output logic [`ANT_COUNT-1:0] s_re,
                              output logic [`ANT_COUNT-1:0] s_im);
      logic [31:0] rnd;
      case (mode)
         MODE_ONES: begin
            s_re = '1;
            s_im = '1;
         end
         MODE_ALT: begin
            // Odd and even antennas opposite, flipped every sample
            s_re = idx[0] ? {(`ANT_COUNT / 2){2'b01}} : {(`ANT_COUNT / 2){2'b10}};
            s_im = ~s_re;
         end
         default: begin
            rnd  = $urandom();
            s_re = rnd[`ANT_COUNT-1:0];
            rnd  = $urandom();
            s_im = rnd[`ANT_COUNT-1:0];
         end
      endcase
   endtask

   // Twelve words of the coming dump pass
   task automatic push_expected();
      for (int k = 0; k < `MRATE; k++) begin
         exp_vis_q.push_back(expected_vis(k));
         exp_slot_q.push_back(slot_t'(k));
      end
   endtask

   task automatic send_sample(input logic [`ANT_COUNT-1:0] s_re,
                              input logic [`ANT_COUNT-1:0] s_im,
                              input bit with_drop);
      logic [31:0] rnd;
      @(posedge clk_x);
      sample_vld <= 1'b1;
      re         <= s_re;
      im         <= s_im;
      // DUT takes the strobe on the coming edge
      @(negedge clk_x);
      assert (!busy) else begin
         errors = errors + 1;
         $display("ERROR %0t: sample offered while busy", $time);
      end
      @(posedge clk_x);
      sample_vld <= 1'b0;
      if (with_drop) begin
         // Extra strobe mid-pass, must be dropped
         repeat (3) @(posedge clk_x);
         rnd = $urandom();
         sample_vld <= 1'b1;
         re         <= rnd[`ANT_COUNT-1:0];
         im         <= ~rnd[`ANT_COUNT-1:0];
         @(posedge clk_x);
         sample_vld <= 1'b0;
         @(negedge clk_x);
         assert (missed) else begin
            errors = errors + 1;
            $display("ERROR %0t: missed low after a sample during a pass", $time);
         end
         repeat (SPACING - 6) @(posedge clk_x);
      end else begin
         repeat (SPACING - 2) @(posedge clk_x);
      end
   endtask

   // Pass finished and every dump word seen
   task automatic wait_idle();
      @(negedge clk_x);
      while (busy || exp_vis_q.size() != 0) begin
         @(negedge clk_x);
      end
   endtask

   task automatic check_quiet_after_reset();
      for (int i = 0; i < 4; i++) begin
         @(negedge clk_x);
         assert (!vis_vld && !busy && !missed && !overflow_cos && !overflow_sin) else begin
            errors = errors + 1;
            $display("ERROR %0t: outputs not idle after reset", $time);
         end
      end
   endtask

   task automatic run_row(input int r);
      row_t                  row;
      logic [`ANT_COUNT-1:0] s_re;
      logic [`ANT_COUNT-1:0] s_im;
      bit                    with_drop;
      int                    blen;
      row  = ROWS[r];
      blen = int'(row.blen);
      @(posedge clk_x);
      block_len <= row.blen;
      cur_blen   = blen;
      for (int b = 0; b < int'(row.n_blocks); b++) begin
         clear_model();
         for (int s = 0; s < blen; s++) begin
            make_sample(row.mode, s, s_re, s_im);
            accumulate_sample(s_re, s_im);
            if (s == blen - 1) begin
               push_expected();
            end
            with_drop = row.miss && (b == 0) && (s == 1);
            send_sample(s_re, s_im, with_drop);
         end
      end
      wait_idle();
      if (row.miss) begin
         exp_missed = 1'b1;
      end
      assert (missed == exp_missed) else begin
         errors = errors + 1;
         $display("ERROR %0t: row %0d missed %0b, expected %0b", $time, r, missed, exp_missed);
      end
      assert (overflow_cos == row.exp_ovf && overflow_sin == row.exp_ovf) else begin
         errors = errors + 1;
         $display("ERROR %0t: row %0d overflow cos %0b sin %0b, expected %0b",
                  $time, r, overflow_cos, overflow_sin, row.exp_ovf);
      end
   endtask

   initial begin : stimulus
      errors     = 0;
      vis_seen   = 0;
      cur_blen   = 1;
      exp_missed = 1'b0;
      rst        <= 1'b1;
      sample_vld <= 1'b0;
      re         <= '0;
      im         <= '0;
      block_len  <= `BLEN_BITS'd1;
      void'($urandom(SEED));
      repeat (RST_CYCLES) @(posedge clk_x);
      rst <= 1'b0;
      check_quiet_after_reset();
      for (int r = 0; r < N_ROWS; r++) begin
         run_row(r);
      end
      $display("Summary: %0d errors, %0d visibilities checked, %0d still expected",
               errors, vis_seen, exp_vis_q.size());
      if (errors == 0 && exp_vis_q.size() == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // --------------------
   // Watchdog
   // --------------------

   // Sized from the table, every sample takes SPACING cycles
   initial begin : watchdog
      int limit;
      limit = RST_CYCLES + WD_MARGIN;
      for (int r = 0; r < N_ROWS; r++) begin
         limit = limit + int'(ROWS[r].n_blocks) * int'(ROWS[r].blen) * SPACING;
      end
      repeat (limit) @(posedge clk_x);
      $display("Simulation stuck, no end after %0d cycles, %0d errors so far",
               limit, errors);
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
+incdir+testbench
src/corr_pkg.sv
src/accum_ram.sv
src/correlate_cos_sin.sv
src/slot_counter.sv
src/corr_sequencer.sv
src/correlator_sdp.sv
src/correlator_top.sv
testbench/tb_correlator.sv

// File: run.sh
#!/bin/sh
# Build and run the correlator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_correlator \
   -f vlog.f

out=$(./obj_dir/Vtb_correlator)
printf '%s\n' "$out"

# Result comes from the testbench summary line
if printf '%s\n' "$out" | grep -qx "Test OK"; then
   exit 0
fi
exit 1
